// ==== verilog/cpu_types_pkg.sv ====
package cpu_types_pkg;

  // Cache geometry of 1024 data bits
  localparam int WORD_W      = 32;
  localparam int NUM_SETS    = 8;
  localparam int NUM_WAYS    = 2;
  localparam int BLOCK_WORDS = 2;
  localparam int IDX_W       = 3;
  localparam int TAG_W       = 26;

  typedef logic [WORD_W-1:0] word_t;

  localparam word_t COUNT_ADDR = 32'h0000_3100;  // Hit count lands here after flush

  // Controller states
  localparam logic [3:0] IDLE   = 4'd0;
  localparam logic [3:0] WB0    = 4'd1;
  localparam logic [3:0] WB1    = 4'd2;
  localparam logic [3:0] LOAD0  = 4'd3;
  localparam logic [3:0] LOAD1  = 4'd4;
  localparam logic [3:0] FLUSH  = 4'd5;
  localparam logic [3:0] WRITE0 = 4'd6;
  localparam logic [3:0] WRITE1 = 4'd7;
  localparam logic [3:0] COUNT  = 4'd8;
  localparam logic [3:0] HALT   = 4'd9;

  // Same word seen as a byte address or as cache fields
  typedef union packed {
    word_t raw;
    struct packed {
      logic [TAG_W-1:0] tag;
      logic [IDX_W-1:0] idx;
      logic             blkoff;
      logic [1:0]       bytoff;
    } f;
  } dcachef_t;

endpackage

// ==== verilog/datapath_cache_if.sv ====
`timescale 1ns/1ps

interface datapath_cache_if import cpu_types_pkg::*; ();

  logic  halt;
  logic  dmemREN, dmemWEN;
  word_t dmemaddr, dmemstore;
  logic  dhit;
  word_t dmemload;
  logic  flushed;

  modport array (
    input  halt, dmemREN, dmemWEN, dmemaddr, dmemstore,
    output dhit, dmemload
  );

  modport ctrl (
    input  halt, dmemaddr,
    output flushed
  );

endinterface

// ==== verilog/caches_if.sv ====
`timescale 1ns/1ps

interface caches_if import cpu_types_pkg::*; ();

  logic  dREN, dWEN;
  word_t daddr, dstore;
  word_t dload;
  logic  dwait;   // High while the word is pending

  modport dcache (
    input  dload, dwait,
    output dREN, dWEN, daddr, dstore
  );

  // Arbiter side
  modport mem (
    input  dREN, dWEN, daddr, dstore,
    output dload, dwait
  );

endinterface

// ==== verilog/dcache_array.sv ====
`timescale 1ns/1ps

module dcache_array import cpu_types_pkg::*; (
  input  logic             CLK,
  input  logic             nRST,
  datapath_cache_if.array  dcif,
  input  logic             lookup_en,
  input  logic             fill_we,
  input  logic             fill_word,
  input  logic             fill_done,
  input  logic             evict_clean,
  input  logic             flush_clean,
  input  logic             flush_way,
  input  word_t            fill_data,
  input  logic [IDX_W-1:0] flush_idx,
  output logic             miss,
  output logic             victim_dirty,
  output logic [TAG_W-1:0] victim_tag,
  input  logic             rd_sel_word,
  output word_t            rd_data,
  output logic             frame_dirty,
  output logic [TAG_W-1:0] frame_tag,
  output logic             hit
);

  word_t            data [NUM_SETS][NUM_WAYS][BLOCK_WORDS];
  logic [TAG_W-1:0] tags [NUM_SETS][NUM_WAYS];

  logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid;
  logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty;
  logic [NUM_SETS-1:0]               lru;   // Way to replace next
  logic                              flush_mode;

  dcachef_t         req;
  logic [IDX_W-1:0] set;
  logic             match0, match1;
  logic             access;
  logic             hit_way, vict_way;

  assign req.raw = dcif.dmemaddr;
  assign set     = req.f.idx;

  assign match0  = valid[set][0] && (tags[set][0] == req.f.tag);
  assign match1  = valid[set][1] && (tags[set][1] == req.f.tag);
  assign hit_way = !match0;

  // Lookups only in IDLE and never once halt is up
  assign access = lookup_en && !dcif.halt && (dcif.dmemREN || dcif.dmemWEN);

  assign hit           = access && (match0 || match1);
  assign miss          = access && !(match0 || match1);
  assign dcif.dhit     = hit;
  assign dcif.dmemload = data[set][hit_way][req.f.blkoff];

  // Empty way first, otherwise LRU
  assign vict_way = !valid[set][0] ? 1'b0 : (!valid[set][1] ? 1'b1 : lru[set]);

  assign victim_dirty = dirty[set][vict_way];
  assign victim_tag   = tags[set][vict_way];
  assign frame_dirty  = dirty[flush_idx][flush_way];
  assign frame_tag    = tags[flush_idx][flush_way];

  // Flush walk owns the read port once the halt is taken
  assign rd_data = flush_mode ? data[flush_idx][flush_way][rd_sel_word]
                              : data[set][vict_way][rd_sel_word];

  always_ff @(posedge CLK) begin
    if (hit && dcif.dmemWEN)
      data[set][hit_way][req.f.blkoff] <= dcif.dmemstore;
    if (fill_we)
      data[set][vict_way][fill_word] <= fill_data;
    if (fill_done)
      tags[set][vict_way] <= req.f.tag;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid      <= '0;
      dirty      <= '0;
      lru        <= '0;
      flush_mode <= 1'b0;
    end else begin
      if (hit) begin
        lru[set] <= ~hit_way;   // Point at the other way
        if (dcif.dmemWEN)
          dirty[set][hit_way] <= 1'b1;
      end
      if (fill_done) begin
        valid[set][vict_way] <= 1'b1;
        dirty[set][vict_way] <= 1'b0;
      end
      if (evict_clean) begin
        valid[set][vict_way] <= 1'b0;
        dirty[set][vict_way] <= 1'b0;
      end
      if (flush_clean) begin
        valid[flush_idx][flush_way] <= 1'b0;
        dirty[flush_idx][flush_way] <= 1'b0;
      end
      if (lookup_en && dcif.halt)
        flush_mode <= 1'b1;   // Controller heads to FLUSH here
    end
  end

endmodule

// ==== verilog/dcache_counters.sv ====
`timescale 1ns/1ps

module dcache_counters import cpu_types_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       hit,
  input  logic       miss,
  input  logic       flush_step,
  output word_t      hit_count,
  output logic [3:0] flush_pos,
  output logic       flush_done
);

  logic [4:0] pos;   // Extra bit marks the walk as done

  assign flush_pos  = pos[3:0];
  assign flush_done = pos[4];

  // Wrapping count of hits minus misses
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      hit_count <= '0;
    end else if (hit) begin
      hit_count <= hit_count + 32'd1;
    end else if (miss) begin
      hit_count <= hit_count - 32'd1;
    end
  end

  // Way 0 sets first, then way 1 sets
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pos <= '0;
    end else if (flush_step && !flush_done) begin
      pos <= pos + 5'd1;
    end
  end

endmodule

// ==== verilog/dcache_control.sv ====
`timescale 1ns/1ps

module dcache_control import cpu_types_pkg::*; (
  input  logic             CLK,
  input  logic             nRST,
  datapath_cache_if.ctrl   dcif,
  caches_if.dcache         cif,
  output logic             lookup_en,
  output logic             fill_we,
  output logic             fill_word,
  output logic             fill_done,
  output logic             evict_clean,
  output logic             flush_clean,
  output logic [IDX_W-1:0] flush_idx,
  output logic             flush_way,
  output logic             rd_sel_word,
  input  logic             miss,
  input  logic             victim_dirty,
  input  logic             frame_dirty,
  input  logic             flush_done,
  input  logic [TAG_W-1:0] victim_tag,
  input  logic [TAG_W-1:0] frame_tag,
  input  word_t            rd_data,
  input  word_t            hit_count,
  input  logic [3:0]       flush_pos,
  output logic             flush_step
);

  logic [3:0] state, next_state;
  dcachef_t   req, mem_a;
  logic       mem_done;

  assign req.raw  = dcif.dmemaddr;
  assign mem_done = !cif.dwait;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (dcif.halt)
          next_state = FLUSH;
        else if (miss)
          next_state = victim_dirty ? WB0 : LOAD0;
      end
      WB0:    if (mem_done) next_state = WB1;
      WB1:    if (mem_done) next_state = LOAD0;
      LOAD0:  if (mem_done) next_state = LOAD1;
      LOAD1:  if (mem_done) next_state = IDLE;   // Request hits on return
      FLUSH: begin
        if (flush_done)
          next_state = COUNT;
        else if (frame_dirty)
          next_state = WRITE0;
      end
      WRITE0: if (mem_done) next_state = WRITE1;
      WRITE1: if (mem_done) next_state = FLUSH;
      COUNT:  if (mem_done) next_state = HALT;
      HALT:   next_state = HALT;
      default: next_state = IDLE;
    endcase
  end

  assign lookup_en   = (state == IDLE);
  assign fill_word   = (state == LOAD1);
  assign fill_we     = ((state == LOAD0) || (state == LOAD1)) && mem_done;
  assign fill_done   = (state == LOAD1) && mem_done;
  assign evict_clean = (state == WB1) && mem_done;
  assign flush_clean = (state == WRITE1) && mem_done;
  assign rd_sel_word = (state == WB1) || (state == WRITE1);

  // Clean frames pass in one cycle
  assign flush_step = flush_clean || ((state == FLUSH) && !flush_done && !frame_dirty);
  assign flush_idx  = flush_pos[2:0];
  assign flush_way  = flush_pos[3];

  assign dcif.flushed = (state == HALT);

  // Memory side address and data
  always_comb begin
    cif.dREN   = 1'b0;
    cif.dWEN   = 1'b0;
    cif.dstore = '0;
    mem_a.raw  = '0;
    case (state)
      WB0, WB1: begin
        cif.dWEN       = 1'b1;
        mem_a.f.tag    = victim_tag;
        mem_a.f.idx    = req.f.idx;
        mem_a.f.blkoff = rd_sel_word;
        cif.dstore     = rd_data;
      end
      LOAD0, LOAD1: begin
        cif.dREN       = 1'b1;
        mem_a.f.tag    = req.f.tag;
        mem_a.f.idx    = req.f.idx;
        mem_a.f.blkoff = fill_word;
      end
      WRITE0, WRITE1: begin
        cif.dWEN       = 1'b1;
        mem_a.f.tag    = frame_tag;
        mem_a.f.idx    = flush_idx;
        mem_a.f.blkoff = rd_sel_word;
        cif.dstore     = rd_data;
      end
      COUNT: begin
        cif.dWEN   = 1'b1;
        mem_a.raw  = COUNT_ADDR;
        cif.dstore = hit_count;
      end
      default: ;   // No memory traffic
    endcase
  end

  assign cif.daddr = mem_a.raw;

endmodule

// ==== verilog/dcache.sv ====
`timescale 1ns/1ps

module dcache import cpu_types_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  halt,
  input  logic  dmemREN,
  input  logic  dmemWEN,
  input  word_t dmemaddr,
  input  word_t dmemstore,
  input  word_t dload,
  input  logic  dwait,
  output logic  dhit,
  output logic  flushed,
  output logic  dREN,
  output logic  dWEN,
  output word_t dmemload,
  output word_t daddr,
  output word_t dstore
);

  datapath_cache_if dcif ();
  caches_if         cif ();

  logic             lookup_en, fill_we, fill_word, fill_done;
  logic             evict_clean, flush_clean, flush_way, rd_sel_word;
  logic [IDX_W-1:0] flush_idx;
  logic             miss, hit, victim_dirty, frame_dirty;
  logic [TAG_W-1:0] victim_tag, frame_tag;
  word_t            rd_data, hit_count;
  logic [3:0]       flush_pos;
  logic             flush_step, flush_done;

  // Processor side
  assign dcif.halt      = halt;
  assign dcif.dmemREN   = dmemREN;
  assign dcif.dmemWEN   = dmemWEN;
  assign dcif.dmemaddr  = dmemaddr;
  assign dcif.dmemstore = dmemstore;
  assign dhit           = dcif.dhit;
  assign dmemload       = dcif.dmemload;
  assign flushed        = dcif.flushed;

  // Memory side
  assign cif.dload = dload;
  assign cif.dwait = dwait;
  assign dREN      = cif.dREN;
  assign dWEN      = cif.dWEN;
  assign daddr     = cif.daddr;
  assign dstore    = cif.dstore;

  dcache_array u_array (
    .CLK, .nRST,
    .dcif         (dcif),
    .lookup_en, .fill_we, .fill_word, .fill_done,
    .evict_clean, .flush_clean, .flush_way,
    .fill_data    (cif.dload),
    .flush_idx,
    .miss, .victim_dirty, .victim_tag,
    .rd_sel_word, .rd_data,
    .frame_dirty, .frame_tag,
    .hit
  );

  dcache_counters u_counters (
    .CLK, .nRST,
    .hit, .miss, .flush_step,
    .hit_count, .flush_pos, .flush_done
  );

  dcache_control u_control (
    .CLK, .nRST,
    .dcif         (dcif),
    .cif          (cif),
    .lookup_en, .fill_we, .fill_word, .fill_done,
    .evict_clean, .flush_clean, .flush_idx, .flush_way, .rd_sel_word,
    .miss, .victim_dirty, .frame_dirty, .flush_done,
    .victim_tag, .frame_tag,
    .rd_data, .hit_count, .flush_pos,
    .flush_step
  );

endmodule

// ==== verification/dcache_sva.sv ====
`timescale 1ns/1ps

module dcache_sva import cpu_types_pkg::*; (
  input logic  CLK,
  input logic  nRST,
  input logic  dREN,
  input logic  dWEN,
  input logic  dwait,
  input word_t daddr,
  input logic  flushed
);

  int fails = 0;

  one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
    else begin
      $error("dREN and dWEN high in the same cycle");
      fails++;
    end

  // Memory word held until dwait drops
  addr_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (dREN || dWEN) && dwait |=> $stable(daddr))
    else begin
      $error("daddr changed while dwait was high");
      fails++;
    end

  flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
    else begin
      $error("flushed fell after rising");
      fails++;
    end

endmodule

bind dcache_control dcache_sva u_sva (
  .CLK, .nRST,
  .dREN    (cif.dREN),
  .dWEN    (cif.dWEN),
  .dwait   (cif.dwait),
  .daddr   (cif.daddr),
  .flushed (dcif.flushed)
);

// ==== verification/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb import cpu_types_pkg::*; ();

  logic  CLK, nRST, halt, dmemREN, dmemWEN, dwait;
  word_t dmemaddr, dmemstore, dload;
  logic  dhit, flushed, dREN, dWEN;
  word_t dmemload, daddr, dstore;

  dcache dut (.*);

  integer seed = 68105;
  int     errors, checks, test_errs;

  // Memory model state
  word_t mem [word_t];
  word_t act_wa[$], act_wd[$];
  int    wait_left, reads_seen;
  logic  armed, order_err;

  // Reference cache
  word_t            ref_mem [word_t];
  word_t            exp_wa[$], exp_wd[$];
  logic             rv     [NUM_SETS][NUM_WAYS];
  logic             rdirty [NUM_SETS][NUM_WAYS];
  logic [TAG_W-1:0] rtag   [NUM_SETS][NUM_WAYS];
  word_t            rdat   [NUM_SETS][NUM_WAYS][BLOCK_WORDS];
  logic             rlru   [NUM_SETS];
  word_t            ref_count;

  event  acc_done;   // One finished access for the compare process
  string cur_name;
  logic  cur_wen;
  word_t cur_exp, cur_act;

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  function automatic word_t mem_pattern(input word_t addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
  endfunction

  function automatic word_t mk_addr(input int tag, input int idx, input int blk);
    return {tag[TAG_W-1:0], idx[IDX_W-1:0], blk[0], 2'b00};
  endfunction

  function automatic word_t ref_read(input word_t addr);
    return ref_mem.exists(addr) ? ref_mem[addr] : mem_pattern(addr);
  endfunction

  function void expect_write(input word_t addr, input word_t data);
    exp_wa.push_back(addr);
    exp_wd.push_back(data);
    ref_mem[addr] = data;
  endfunction

  function word_t ref_access(input logic wen, input word_t addr, input word_t wdata);
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             blk, way, hit0, hit1;
    idx  = addr[5:3];
    tag  = addr[31:6];
    blk  = addr[2];
    hit0 = rv[idx][0] && (rtag[idx][0] == tag);
    hit1 = rv[idx][1] && (rtag[idx][1] == tag);
    if (hit0 || hit1) begin
      way       = !hit0;
      ref_count = ref_count + 1;
    end else begin
      ref_count = ref_count - 1;
      way = !rv[idx][0] ? 1'b0 : (!rv[idx][1] ? 1'b1 : rlru[idx]);
      if (rdirty[idx][way]) begin
        expect_write({rtag[idx][way], idx, 1'b0, 2'b00}, rdat[idx][way][0]);
        expect_write({rtag[idx][way], idx, 1'b1, 2'b00}, rdat[idx][way][1]);
      end
      rdat[idx][way][0] = ref_read({tag, idx, 1'b0, 2'b00});
      rdat[idx][way][1] = ref_read({tag, idx, 1'b1, 2'b00});
      rtag[idx][way]    = tag;
      rv[idx][way]      = 1'b1;
      rdirty[idx][way]  = 1'b0;
      ref_count         = ref_count + 1;   // Refill hit
    end
    if (wen) begin
      rdat[idx][way][blk] = wdata;
      rdirty[idx][way]    = 1'b1;
    end
    rlru[idx] = ~way;
    return rdat[idx][way][blk];
  endfunction

  // Way 0 sets first, then way 1, then the count store
  function void ref_flush();
    for (int w = 0; w < NUM_WAYS; w++)
      for (int s = 0; s < NUM_SETS; s++)
        if (rdirty[s][w]) begin
          for (int b = 0; b < BLOCK_WORDS; b++)
            expect_write({rtag[s][w], s[IDX_W-1:0], b[0], 2'b00}, rdat[s][w][b]);
          rdirty[s][w] = 1'b0;
        end
    expect_write(COUNT_ADDR, ref_count);
  endfunction

  task automatic report_value(input string name, input word_t expv, input word_t actv);
    $display("FAIL %s expected %h actual %h", name, expv, actv);
    errors++;
    test_errs++;
  endtask

  task automatic report_plain(input string msg);
    $display("ERROR %s", msg);
    errors++;
    test_errs++;
  endtask

  task automatic abort(input string msg);
    $display("ERROR %s", msg);
    $display("Result: FAILED");
    $finish;
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0)
      $display("test %-12s ok", name);
    else
      $display("test %-12s %0d errors", name, test_errs);
    test_errs = 0;
  endtask

  task automatic check_writes(input string name);
    checks++;
    if (act_wa.size() != exp_wa.size()) begin
      report_plain($sformatf("%s made %0d memory writes instead of %0d",
                             name, act_wa.size(), exp_wa.size()));
    end else begin
      foreach (exp_wa[i]) begin
        if (act_wa[i] !== exp_wa[i])
          report_value({name, " write address"}, exp_wa[i], act_wa[i]);
        if (act_wd[i] !== exp_wd[i])
          report_value({name, " write data"}, exp_wd[i], act_wd[i]);
      end
    end
    if (order_err)
      report_plain({name, " wrote to memory after a fill read"});
    act_wa.delete();
    act_wd.delete();
    exp_wa.delete();
    exp_wd.delete();
    reads_seen = 0;
    order_err  = 1'b0;
  endtask

  // Memory answers each word after 0 to 3 wait cycles
  always @(negedge CLK) begin
    if (dREN || dWEN) begin
      if (!armed) begin
        wait_left = $unsigned($random(seed)) % 4;
        armed     = 1'b1;
      end
      dload = mem.exists(daddr) ? mem[daddr] : mem_pattern(daddr);
      if (wait_left > 0) begin
        dwait     = 1'b1;
        wait_left = wait_left - 1;
      end else begin
        dwait = 1'b0;
        armed = 1'b0;
      end
    end else begin
      dwait = 1'b1;
      armed = 1'b0;
    end
  end

  always @(posedge CLK) begin
    if (dWEN && !dwait) begin
      mem[daddr] = dstore;
      act_wa.push_back(daddr);
      act_wd.push_back(dstore);
      if (reads_seen > 0)
        order_err = 1'b1;
    end
    if (dREN && !dwait)
      reads_seen = reads_seen + 1;
  end

  task automatic do_access(input string name, input logic wen, input word_t addr,
                           input word_t wdata);
    word_t expect_val;
    int    cycles;
    expect_val = ref_access(wen, addr, wdata);
    @(negedge CLK);
    dmemREN   = !wen;
    dmemWEN   = wen;
    dmemaddr  = addr;
    dmemstore = wdata;
    cycles    = 0;
    @(posedge CLK);
    while (!dhit && cycles < 100) begin
      cycles++;
      @(posedge CLK);
    end
    if (!dhit) begin
      abort($sformatf("%s got no dhit for address %h within 100 cycles", name, addr));
    end else begin
      cur_name = name;
      cur_wen  = wen;
      cur_exp  = expect_val;
      cur_act  = dmemload;
      -> acc_done;
      @(negedge CLK);
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
    end
  endtask

  initial begin
    forever begin
      @(acc_done);
      checks++;
      if (!cur_wen && (cur_act !== cur_exp))
        report_value({cur_name, " load"}, cur_exp, cur_act);
      check_writes(cur_name);
    end
  end

  initial begin
    word_t r;
    int    cycles;
    halt       = 1'b0;
    dmemREN    = 1'b0;
    dmemWEN    = 1'b0;
    dmemaddr   = '0;
    dmemstore  = '0;
    dload      = '0;
    dwait      = 1'b1;
    armed      = 1'b0;
    wait_left  = 0;
    reads_seen = 0;
    order_err  = 1'b0;
    errors     = 0;
    checks     = 0;
    test_errs  = 0;
    ref_count  = '0;
    for (int s = 0; s < NUM_SETS; s++) begin
      rlru[s] = 1'b0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        rv[s][w]     = 1'b0;
        rdirty[s][w] = 1'b0;
      end
    end
    nRST = 1'b0;
    repeat (3) @(negedge CLK);
    nRST = 1'b1;

    do_access("fill_hit", 1'b1, mk_addr(1, 2, 0), 32'h1111_0001);
    do_access("fill_hit", 1'b0, mk_addr(1, 2, 0), '0);
    do_access("fill_hit", 1'b0, mk_addr(1, 2, 1), '0);
    do_access("fill_hit", 1'b1, mk_addr(1, 2, 1), 32'h1111_0002);
    do_access("fill_hit", 1'b0, mk_addr(1, 2, 1), '0);
    end_test("fill_hit");

    // Three tags fight over set 3
    do_access("lru_evict", 1'b1, mk_addr(10, 3, 0), 32'hA0A0_0010);
    do_access("lru_evict", 1'b1, mk_addr(11, 3, 1), 32'hA0A0_0011);
    do_access("lru_evict", 1'b0, mk_addr(10, 3, 0), '0);
    do_access("lru_evict", 1'b1, mk_addr(12, 3, 0), 32'hA0A0_0012);  // Tag 11 goes out
    do_access("lru_evict", 1'b0, mk_addr(11, 3, 1), '0);   // Comes back from memory
    do_access("lru_evict", 1'b0, mk_addr(10, 3, 0), '0);
    do_access("lru_evict", 1'b0, mk_addr(11, 3, 1), '0);   // Hit on the refilled block
    end_test("lru_evict");

    do_access("clean_dirty", 1'b0, mk_addr(20, 5, 0), '0);
    do_access("clean_dirty", 1'b0, mk_addr(21, 5, 0), '0);
    do_access("clean_dirty", 1'b0, mk_addr(22, 5, 1), '0);   // Clean victim
    do_access("clean_dirty", 1'b1, mk_addr(22, 5, 1), 32'hBEEF_0022);
    do_access("clean_dirty", 1'b0, mk_addr(20, 5, 0), '0);
    do_access("clean_dirty", 1'b0, mk_addr(21, 5, 0), '0);   // Dirty tag 22 evicted
    end_test("clean_dirty");

    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      do_access("random", r[0], mk_addr(1 + r[3:2], r[6:4], r[7]), $random(seed));
    end
    end_test("random");

    @(negedge CLK);
    halt = 1'b1;
    ref_flush();
    cycles = 0;
    while (!flushed && cycles < 2000) begin
      cycles++;
      @(negedge CLK);
    end
    if (!flushed) begin
      abort("flushed did not rise within 2000 cycles after halt");
    end else begin
      checks++;
      if (act_wa.size() == 0) begin
        report_plain("no memory write during the flush");
      end else begin
        if (act_wa[$] !== COUNT_ADDR)
          report_value("hit_count address", COUNT_ADDR, act_wa[$]);
        if (act_wd[$] !== ref_count)
          report_value("hit_count", ref_count, act_wd[$]);
      end
      end_test("hit_count");
      check_writes("flush");
      foreach (ref_mem[a]) begin
        checks++;
        if (!mem.exists(a))
          report_plain($sformatf("flush left address %h unwritten", a));
        else if (mem[a] !== ref_mem[a])
          report_value("flush memory", ref_mem[a], mem[a]);
      end
      if (mem.num() != ref_mem.num())
        report_plain("memory holds writes the reference cache never made");
      for (int i = 0; i < 8; i++) begin
        @(negedge CLK);
        if (!flushed)
          report_plain("flushed fell after rising");
      end
      end_test("flush");
      if (dut.u_control.u_sva.fails != 0)
        report_plain($sformatf("%0d protocol assertions failed", dut.u_control.u_sva.fails));
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
        $display("Result: PASSED");
      else
        $display("Result: FAILED");
      $finish;
    end
  end

endmodule

// ==== src.f ====
verilog/cpu_types_pkg.sv
verilog/datapath_cache_if.sv
verilog/caches_if.sv
verilog/dcache_array.sv
verilog/dcache_counters.sv
verilog/dcache_control.sv
verilog/dcache.sv
verification/dcache_sva.sv
verification/dcache_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= dcache_tb
RTL_TOP    ?= dcache
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
